//--- src/ahbPkg.sv
// AHB-Lite codes for the slave only; bursts arrive as single transfers and sizes above word are unsupported
`default_nettype none

package ahbPkg;

    // HTRANS code that carries no transfer
    localparam logic [1:0] htransIdle = 2'b00;

    // Supported HSIZE codes
    localparam logic [2:0] hsizeByte = 3'b000;
    localparam logic [2:0] hsizeHalf = 3'b001;
    localparam logic [2:0] hsizeWord = 3'b010;

endpackage

`default_nettype wire

//--- src/sdramPkg.sv
// One x16 device with 4 banks, 8192 rows, 1024 columns; mode is fixed to CAS 2, sequential, burst 2
`default_nettype none

package sdramPkg;

    // Device geometry, one word each
    localparam int rowBits  = 13;
    localparam int colBits  = 10;
    localparam int bankBits = 2;

    // A10 selects all banks on PRECHARGE and auto precharge on READ/WRITE
    localparam int a10Bit = 10;

    // Commands as {CKE, CSn, RASn, CASn, WEn}
    localparam logic [4:0] cmdNopNcke      = 5'b00111;
    localparam logic [4:0] cmdNop          = 5'b10111;
    localparam logic [4:0] cmdPrechargeAll = 5'b10010;
    localparam logic [4:0] cmdAutoRefresh  = 5'b10001;
    localparam logic [4:0] cmdLoadModeReg  = 5'b10000;
    localparam logic [4:0] cmdActive       = 5'b10011;
    localparam logic [4:0] cmdRead         = 5'b10101;
    localparam logic [4:0] cmdWrite        = 5'b10100;

    // Mode register fields
    localparam logic [2:0] modeCas2       = 3'b010;
    localparam logic       modeSequential = 1'b0;
    localparam logic [2:0] modeBurst2     = 3'b001;

    // SDRAM view of an AHB byte address
    // Column bit 0 is implied zero, one burst of 2 covers a word
    typedef struct packed {
        logic                pad;
        logic [4:0]          unused;
        logic [bankBits-1:0] bank;
        logic [rowBits-1:0]  row;
        logic [colBits-2:0]  colWord;
        logic [1:0]          byteOff;
    } sdramFieldsT;

    // Same 32 bits, flat from AHB or split for the pins
    typedef union packed {
        logic [31:0] flat;
        sdramFieldsT field;
    } sdramAddrT;

    // Sequencer states
    typedef enum logic [4:0] {
        sIdle,
        // Power-up
        sInit0Ncke,
        sInit1Ncke,
        sInit2Cke,
        sInit3Nop,
        sInit4PrechAll,
        sInit5Nop,
        sInit6PreRef,
        sInit7AutoRef,
        sInit8Nop,
        sInit9Lmr,
        sInit10Nop,
        // Read with auto precharge
        sRead0Act,
        sRead1Nop,
        sRead2Read,
        sRead3Nop,
        sRead4Rd0,
        sRead5Rd1,
        sRead6Nop,
        // Write with auto precharge
        sWrite0Act,
        sWrite1Nop,
        sWrite2Wr0,
        sWrite3Wr1,
        sWrite4Nop,
        // Periodic refresh
        sAref0AutoRef,
        sAref1Nop
    } seqStateT;

endpackage

`default_nettype wire

//--- src/ahbCapture.sv
// One transfer in flight; HRESP is always OKAY and HRDATA holds the last read until the next one
`default_nettype none

module ahbCapture (
    input  wire                 HCLK,
    input  wire                 HRESETn,
    input  wire                 HSEL,
    input  wire  [31:0]         HADDR,
    input  wire  [1:0]          HTRANS,
    input  wire                 HWRITE,
    input  wire  [2:0]          HSIZE,
    input  wire  [31:0]         HWDATA,
    input  wire                 HREADY,
    input  wire  sdramPkg::seqStateT state,
    input  wire                 accept,
    input  wire  [15:0]         dqIn,
    output logic                request,
    output logic                reqWrite,
    output sdramPkg::sdramAddrT reqAddr,
    output logic [2:0]          reqSize,
    output logic [31:0]         wrData,
    output logic [31:0]         HRDATA,
    output logic                HREADYOUT,
    output logic                HRESP
);

    logic        writeQ;
    logic        acceptQ;
    logic [15:0] rdLow;

    // Ready only while the FSM waits in idle
    assign HREADYOUT = (state == sdramPkg::sIdle);
    assign HRESP     = 1'b0;

    // Address phase decode
    assign request = HSEL && HREADY && (HTRANS != ahbPkg::htransIdle);

    // Live HWRITE in the accept cycle, latched copy afterwards
    assign reqWrite = HREADYOUT ? HWRITE : writeQ;

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            writeQ  <= 1'b0;
            acceptQ <= 1'b0;
        end else begin
            acceptQ <= accept;
            if (HREADYOUT && request) begin
                writeQ <= HWRITE;
            end
        end
    end

    always_ff @(posedge HCLK) begin
        // Address phase fields
        if (HREADYOUT && request) begin
            reqAddr.flat <= HADDR;
            reqSize      <= HSIZE;
        end
        // Data phase is the cycle after accept
        if (acceptQ && writeQ) begin
            wrData <= HWDATA;
        end
        // Low halfword comes first in the burst
        if (state == sdramPkg::sRead4Rd0) begin
            rdLow <= dqIn;
        end
        if (state == sdramPkg::sRead5Rd1) begin
            HRDATA <= {dqIn, rdLow};
        end
    end

endmodule

`default_nettype wire

//--- src/sdramSequencer.sv
// Waits of zero are skipped; long counter is 24 bits so delayNcke and delayRef must stay below 2**24
`default_nettype none

module sdramSequencer #(
    parameter int delayNcke        = 20,
    parameter int delayRef         = 390,
    parameter int delayRp          = 0,
    parameter int delayRfc         = 2,
    parameter int delayMrd         = 0,
    parameter int delayRcd         = 0,
    parameter int delayCas         = 1,
    parameter int delayAfterRead   = 0,
    parameter int delayAfterWrite  = 2,
    parameter int initRefreshCount = 2
) (
    input  wire                HCLK,
    input  wire                HRESETn,
    input  wire                request,
    input  wire                reqWrite,
    output sdramPkg::seqStateT state,
    output logic               accept
);

    sdramPkg::seqStateT stateNext;
    sdramPkg::seqStateT xferDone;
    logic [7:0]  delayShort;
    logic [23:0] delayLong;
    logic [3:0]  repeatCnt;
    logic        shortDone;
    logic        longZero;

    assign shortDone = (delayShort == '0);
    // Long counter doubles as CKE wait and refresh timer
    assign longZero  = (delayLong == '0);

    // Requests only taken in idle so one transfer at a time
    assign accept = (state == sdramPkg::sIdle) && request;

    // Serve a due refresh after a burst before going ready
    assign xferDone = longZero ? sdramPkg::sAref0AutoRef : sdramPkg::sIdle;

    always_comb begin
        stateNext = state;
        case (state)
            sdramPkg::sIdle: begin
                if (request) begin
                    stateNext = reqWrite ? sdramPkg::sWrite0Act : sdramPkg::sRead0Act;
                end else if (longZero) begin
                    stateNext = sdramPkg::sAref0AutoRef;
                end
            end
            // Power-up
            sdramPkg::sInit0Ncke:     stateNext = sdramPkg::sInit1Ncke;
            sdramPkg::sInit1Ncke:     if (longZero) stateNext = sdramPkg::sInit2Cke;
            sdramPkg::sInit2Cke:      stateNext = sdramPkg::sInit3Nop;
            sdramPkg::sInit3Nop:      stateNext = sdramPkg::sInit4PrechAll;
            sdramPkg::sInit4PrechAll: begin
                stateNext = (delayRp == 0) ? sdramPkg::sInit6PreRef : sdramPkg::sInit5Nop;
            end
            sdramPkg::sInit5Nop:      if (shortDone) stateNext = sdramPkg::sInit6PreRef;
            sdramPkg::sInit6PreRef:   stateNext = sdramPkg::sInit7AutoRef;
            sdramPkg::sInit7AutoRef:  stateNext = sdramPkg::sInit8Nop;
            sdramPkg::sInit8Nop: begin
                if (shortDone) begin
                    stateNext = (repeatCnt == '0) ? sdramPkg::sInit9Lmr : sdramPkg::sInit7AutoRef;
                end
            end
            sdramPkg::sInit9Lmr:      stateNext = sdramPkg::sInit10Nop;
            sdramPkg::sInit10Nop:     if (shortDone) stateNext = sdramPkg::sIdle;
            // Read
            sdramPkg::sRead0Act: begin
                stateNext = (delayRcd == 0) ? sdramPkg::sRead2Read : sdramPkg::sRead1Nop;
            end
            sdramPkg::sRead1Nop:      if (shortDone) stateNext = sdramPkg::sRead2Read;
            sdramPkg::sRead2Read: begin
                stateNext = (delayCas == 0) ? sdramPkg::sRead4Rd0 : sdramPkg::sRead3Nop;
            end
            sdramPkg::sRead3Nop:      if (shortDone) stateNext = sdramPkg::sRead4Rd0;
            sdramPkg::sRead4Rd0:      stateNext = sdramPkg::sRead5Rd1;
            sdramPkg::sRead5Rd1:      stateNext = (delayAfterRead != 0) ? sdramPkg::sRead6Nop : xferDone;
            sdramPkg::sRead6Nop:      if (shortDone) stateNext = xferDone;
            // Write
            sdramPkg::sWrite0Act: begin
                stateNext = (delayRcd == 0) ? sdramPkg::sWrite2Wr0 : sdramPkg::sWrite1Nop;
            end
            sdramPkg::sWrite1Nop:     if (shortDone) stateNext = sdramPkg::sWrite2Wr0;
            sdramPkg::sWrite2Wr0:     stateNext = sdramPkg::sWrite3Wr1;
            sdramPkg::sWrite3Wr1: begin
                stateNext = (delayAfterWrite != 0) ? sdramPkg::sWrite4Nop : xferDone;
            end
            sdramPkg::sWrite4Nop:     if (shortDone) stateNext = xferDone;
            // Refresh
            sdramPkg::sAref0AutoRef:  stateNext = sdramPkg::sAref1Nop;
            sdramPkg::sAref1Nop:      if (shortDone) stateNext = sdramPkg::sIdle;
            default:                  stateNext = sdramPkg::sInit0Ncke;
        endcase
    end

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            state      <= sdramPkg::sInit0Ncke;
            delayShort <= '0;
            delayLong  <= 24'(delayNcke);
            repeatCnt  <= '0;
        end else begin
            state <= stateNext;

            // Short waits loaded one short where a NOP state follows directly
            case (state)
                sdramPkg::sInit4PrechAll: delayShort <= 8'(delayRp - 1);
                sdramPkg::sInit7AutoRef:  delayShort <= 8'(delayRfc);
                sdramPkg::sInit9Lmr:      delayShort <= 8'(delayMrd);
                sdramPkg::sRead0Act:      delayShort <= 8'(delayRcd - 1);
                sdramPkg::sRead2Read:     delayShort <= 8'(delayCas - 1);
                sdramPkg::sRead5Rd1:      delayShort <= 8'(delayAfterRead - 1);
                sdramPkg::sWrite0Act:     delayShort <= 8'(delayRcd - 1);
                sdramPkg::sWrite3Wr1:     delayShort <= 8'(delayAfterWrite - 1);
                sdramPkg::sAref0AutoRef:  delayShort <= 8'(delayRfc);
                default:                  if (!shortDone) delayShort <= delayShort - 8'd1;
            endcase

            // CKE wait counts down from the reset load
            // Refresh interval restarted by every AUTO REFRESH
            case (state)
                sdramPkg::sInit7AutoRef,
                sdramPkg::sAref0AutoRef:  delayLong <= 24'(delayRef);
                default:                  if (!longZero) delayLong <= delayLong - 24'd1;
            endcase

            // Init AUTO REFRESH count
            if (state == sdramPkg::sInit6PreRef) begin
                repeatCnt <= 4'(initRefreshCount);
            end else if (state == sdramPkg::sInit7AutoRef) begin
                repeatCnt <= repeatCnt - 4'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/sdramPinDriver.sv
// Purely combinational; DQ is split into dqOut, dqOutEn and dqIn, the tristate buffer sits outside
`default_nettype none

module sdramPinDriver (
    input  wire  sdramPkg::seqStateT  state,
    input  wire  sdramPkg::sdramAddrT reqAddr,
    input  wire  [2:0]                reqSize,
    input  wire  [31:0]               wrData,
    output logic                      cke,
    output logic                      csN,
    output logic                      rasN,
    output logic                      casN,
    output logic                      weN,
    output logic [sdramPkg::rowBits-1:0]  addr,
    output logic [sdramPkg::bankBits-1:0] ba,
    output logic [1:0]                dqm,
    output logic [15:0]               dqOut,
    output logic                      dqOutEn
);

    logic [4:0] cmd;
    logic [3:0] byteEn;
    logic [sdramPkg::rowBits-1:0] colAddr;

    assign {cke, csN, rasN, casN, weN} = cmd;

    // Column with auto precharge, bit 0 fixed at zero
    always_comb begin
        colAddr = {{(sdramPkg::rowBits - sdramPkg::colBits){1'b0}}, reqAddr.field.colWord, 1'b0};
        colAddr[sdramPkg::a10Bit] = 1'b1;
    end

    always_comb begin
        cmd  = sdramPkg::cmdNop;
        addr = '0;
        ba   = '0;
        // All banks unless a command needs something else
        addr[sdramPkg::a10Bit] = 1'b1;
        case (state)
            sdramPkg::sInit0Ncke,
            sdramPkg::sInit1Ncke:     cmd = sdramPkg::cmdNopNcke;
            sdramPkg::sInit4PrechAll: cmd = sdramPkg::cmdPrechargeAll;
            sdramPkg::sInit7AutoRef,
            sdramPkg::sAref0AutoRef:  cmd = sdramPkg::cmdAutoRefresh;
            sdramPkg::sInit9Lmr: begin
                cmd  = sdramPkg::cmdLoadModeReg;
                addr = {{(sdramPkg::rowBits - 7){1'b0}}, sdramPkg::modeCas2,
                        sdramPkg::modeSequential, sdramPkg::modeBurst2};
            end
            sdramPkg::sRead0Act,
            sdramPkg::sWrite0Act: begin
                cmd  = sdramPkg::cmdActive;
                addr = reqAddr.field.row;
                ba   = reqAddr.field.bank;
            end
            sdramPkg::sRead2Read: begin
                cmd  = sdramPkg::cmdRead;
                addr = colAddr;
                ba   = reqAddr.field.bank;
            end
            sdramPkg::sWrite2Wr0: begin
                cmd  = sdramPkg::cmdWrite;
                addr = colAddr;
                ba   = reqAddr.field.bank;
            end
            default:                  cmd = sdramPkg::cmdNop;
        endcase
    end

    // Bytes touched by the transfer
    always_comb begin
        case (reqSize)
            ahbPkg::hsizeByte: byteEn = 4'b0001 << reqAddr.field.byteOff;
            ahbPkg::hsizeHalf: byteEn = reqAddr.field.byteOff[1] ? 4'b1100 : 4'b0011;
            ahbPkg::hsizeWord: byteEn = 4'b1111;
            default:           byteEn = 4'b1111;
        endcase
    end

    // Low halfword on the first beat, high on the second
    always_comb begin
        dqOut   = '0;
        dqOutEn = 1'b0;
        dqm     = 2'b00;
        if (state == sdramPkg::sWrite2Wr0) begin
            dqOut   = wrData[15:0];
            dqOutEn = 1'b1;
            dqm     = ~byteEn[1:0];
        end else if (state == sdramPkg::sWrite3Wr1) begin
            dqOut   = wrData[31:16];
            dqOutEn = 1'b1;
            dqm     = ~byteEn[3:2];
        end
    end

endmodule

`default_nettype wire

//--- src/ahbSdramTop.sv
// Delay defaults assume fclk near 50 MHz and CAS 2 on the same clock edge; DQ tristate lives on the board
`default_nettype none

module ahbSdramTop #(
    // Cycles with CKE low after reset
    parameter int delayNcke        = 20,
    // Refresh interval
    parameter int delayRef         = 390,
    // Waits after PRECHARGE, AUTO REFRESH, LMR and ACTIVE
    parameter int delayRp          = 0,
    parameter int delayRfc         = 2,
    parameter int delayMrd         = 0,
    parameter int delayRcd         = 0,
    // CAS latency minus one
    parameter int delayCas         = 1,
    // Row cycle time left after the burst
    parameter int delayAfterRead   = 0,
    parameter int delayAfterWrite  = 2,
    parameter int initRefreshCount = 2
) (
    // AHB-Lite side
    input  wire          HCLK,
    input  wire          HRESETn,
    input  wire          HSEL,
    input  wire   [31:0] HADDR,
    input  wire   [1:0]  HTRANS,
    input  wire          HWRITE,
    input  wire   [2:0]  HSIZE,
    input  wire   [31:0] HWDATA,
    input  wire          HREADY,
    output logic  [31:0] HRDATA,
    output logic         HREADYOUT,
    output logic         HRESP,
    // SDRAM side
    output logic         cke,
    output logic         csN,
    output logic         rasN,
    output logic         casN,
    output logic         weN,
    output logic  [sdramPkg::rowBits-1:0]  addr,
    output logic  [sdramPkg::bankBits-1:0] ba,
    output logic  [1:0]  dqm,
    output logic  [15:0] dqOut,
    output logic         dqOutEn,
    input  wire   [15:0] dqIn
);

    sdramPkg::seqStateT state;
    sdramPkg::sdramAddrT reqAddr;
    logic        accept;
    logic        request;
    logic        reqWrite;
    logic [2:0]  reqSize;
    logic [31:0] wrData;

    // Bus side, holds the one transfer in flight
    ahbCapture capture_i (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .HSEL      (HSEL),
        .HADDR     (HADDR),
        .HTRANS    (HTRANS),
        .HWRITE    (HWRITE),
        .HSIZE     (HSIZE),
        .HWDATA    (HWDATA),
        .HREADY    (HREADY),
        .state     (state),
        .accept    (accept),
        .dqIn      (dqIn),
        .request   (request),
        .reqWrite  (reqWrite),
        .reqAddr   (reqAddr),
        .reqSize   (reqSize),
        .wrData    (wrData),
        .HRDATA    (HRDATA),
        .HREADYOUT (HREADYOUT),
        .HRESP     (HRESP)
    );

    // All timing lives in the FSM
    sdramSequencer #(
        .delayNcke        (delayNcke),
        .delayRef         (delayRef),
        .delayRp          (delayRp),
        .delayRfc         (delayRfc),
        .delayMrd         (delayMrd),
        .delayRcd         (delayRcd),
        .delayCas         (delayCas),
        .delayAfterRead   (delayAfterRead),
        .delayAfterWrite  (delayAfterWrite),
        .initRefreshCount (initRefreshCount)
    ) sequencer_i (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .request  (request),
        .reqWrite (reqWrite),
        .state    (state),
        .accept   (accept)
    );

    // State to pins, no storage
    sdramPinDriver pinDriver_i (
        .state   (state),
        .reqAddr (reqAddr),
        .reqSize (reqSize),
        .wrData  (wrData),
        .cke     (cke),
        .csN     (csN),
        .rasN    (rasN),
        .casN    (casN),
        .weN     (weN),
        .addr    (addr),
        .ba      (ba),
        .dqm     (dqm),
        .dqOut   (dqOut),
        .dqOutEn (dqOutEn)
    );

endmodule

`default_nettype wire

//--- verification/sdramModel.sv
// Behavioral x16 SDRAM with no reset; unwritten words read as zero and read data lags READ by one edge
`default_nettype none

module sdramModel #(
    parameter int initRefreshCount = 2
) (
    input  wire         clk,
    input  wire         cke,
    input  wire         csN,
    input  wire         rasN,
    input  wire         casN,
    input  wire         weN,
    input  wire  [12:0] addr,
    input  wire  [1:0]  ba,
    input  wire  [1:0]  dqm,
    input  wire  [15:0] dqOut,
    input  wire         dqOutEn,
    output logic [15:0] dqIn       = '0,
    output logic        initDone   = 1'b0,
    output logic        initError  = 1'b0,
    output logic        burstError = 1'b0,
    output logic [24:0] lastWrKey  = '0
);

    // Storage keyed by {bank, row, column}
    logic [15:0] mem [logic [24:0]];
    logic [12:0] openRow [4];
    logic [4:0]  cmd;
    logic [24:0] key;
    logic [24:0] wrKey;
    logic [24:0] rdKey;
    logic        wrPending = 1'b0;
    logic        rowOpen   = 1'b0;
    int          rdLeft    = 0;
    int          burstLeft = 0;
    int          initStep  = 0;
    int          refCount  = 0;

    assign cmd = {cke, csN, rasN, casN, weN};
    assign key = {ba, openRow[ba], addr[9:0]};

    function automatic logic [15:0] readWord(input logic [24:0] k);
        readWord = mem.exists(k) ? mem[k] : 16'h0000;
    endfunction

    // DQM high keeps the old byte
    function automatic logic [15:0] mergeBytes(input logic [15:0] old, input logic [15:0] d,
                                               input logic [1:0] m);
        mergeBytes = old;
        if (!m[0]) mergeBytes[7:0] = d[7:0];
        if (!m[1]) mergeBytes[15:8] = d[15:8];
    endfunction

    always @(posedge clk) begin
        // Read beats with the low column first
        if (rdLeft != 0) begin
            dqIn   <= readWord(rdKey);
            rdKey  <= rdKey + 25'd1;
            rdLeft <= rdLeft - 1;
        end
        // Second write beat
        if (wrPending) begin
            if (!dqOutEn) burstError <= 1'b1;
            mem[wrKey] = mergeBytes(readWord(wrKey), dqOut, dqm);
            wrPending <= 1'b0;
        end
        if (burstLeft != 0) burstLeft <= burstLeft - 1;

        if (initStep < 2) begin
            // Power-up order
            if (cmd == sdramPkg::cmdPrechargeAll && initStep == 0) begin
                if (!addr[sdramPkg::a10Bit]) initError <= 1'b1;
                initStep <= 1;
            end else if (cmd == sdramPkg::cmdAutoRefresh && initStep == 1) begin
                refCount <= refCount + 1;
            end else if (cmd == sdramPkg::cmdLoadModeReg && initStep == 1) begin
                if (refCount != initRefreshCount) initError <= 1'b1;
                if (addr[6:0] != {sdramPkg::modeCas2, sdramPkg::modeSequential,
                                  sdramPkg::modeBurst2}) initError <= 1'b1;
                initDone <= 1'b1;
                initStep <= 2;
            end else if (cmd != sdramPkg::cmdNop && cmd != sdramPkg::cmdNopNcke) begin
                initError <= 1'b1;
            end
        end else if (cmd == sdramPkg::cmdActive) begin
            if (rowOpen || burstLeft != 0) burstError <= 1'b1;
            openRow[ba] <= addr;
            rowOpen     <= 1'b1;
        end else if (cmd == sdramPkg::cmdRead || cmd == sdramPkg::cmdWrite) begin
            // Auto precharge is mandatory here
            if (!rowOpen || burstLeft != 0 || !addr[sdramPkg::a10Bit]) burstError <= 1'b1;
            rowOpen   <= 1'b0;
            burstLeft <= 3;
            if (cmd == sdramPkg::cmdRead) begin
                rdKey  <= key;
                rdLeft <= 2;
            end else begin
                if (!dqOutEn) burstError <= 1'b1;
                mem[key] = mergeBytes(readWord(key), dqOut, dqm);
                wrKey     <= key + 25'd1;
                wrPending <= 1'b1;
                lastWrKey <= key;
            end
        end else if (cmd != sdramPkg::cmdNop) begin
            if (rowOpen || burstLeft != 0) burstError <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verification/ahbSdramTb.sv
// Single AHB master tied to the slave's HREADYOUT; delayRef is shortened so refresh spacing fits a short run
`default_nettype none

module ahbSdramTb;

    localparam int clkPeriod        = 4;
    localparam int delayNcke        = 20;
    localparam int delayRef         = 40;
    localparam int delayRfc         = 2;
    localparam int initRefreshCount = 2;
    localparam logic [1:0] htransNonseq = 2'b10;
    // Longest allowed AUTO REFRESH spacing while idle
    localparam int refLimit      = delayRef + delayRfc + 2;
    localparam int idleCycles    = 4 * refLimit;
    localparam int numXfers      = 70;
    localparam int initCycles    = 4 + delayNcke + 10 + initRefreshCount * (delayRfc + 2);
    localparam int xferCycles    = 16 + delayRfc;
    localparam int timeoutCycles = 2 * (initCycles + idleCycles + numXfers * xferCycles);

    logic        HCLK;
    logic        HRESETn;
    logic        HSEL;
    logic [31:0] HADDR;
    logic [1:0]  HTRANS;
    logic        HWRITE;
    logic [2:0]  HSIZE;
    logic [31:0] HWDATA;
    logic        HREADY;
    logic [31:0] HRDATA;
    logic        HREADYOUT;
    logic        HRESP;
    logic        cke, csN, rasN, casN, weN;
    logic [12:0] addr;
    logic [1:0]  ba;
    logic [1:0]  dqm;
    logic [15:0] dqOut;
    logic        dqOutEn;
    logic [15:0] dqIn;
    logic        initDone, initError, burstError;
    logic [24:0] lastWrKey;

    // Reference memory by word address
    logic [31:0] refMem [logic [29:0]];
    logic [31:0] pool [8];
    int   seed        = 32;
    int   refGap      = 0;
    int   ckeLowCycles = 0;
    logic ckeSeenHigh = 1'b0;
    logic idleCheck   = 1'b0;

    // Only slave on the bus
    assign HREADY = HREADYOUT;

    ahbSdramTop #(
        .delayNcke        (delayNcke),
        .delayRef         (delayRef),
        .delayRfc         (delayRfc),
        .initRefreshCount (initRefreshCount)
    ) dut_i (
        .HCLK (HCLK), .HRESETn (HRESETn), .HSEL (HSEL), .HADDR (HADDR),
        .HTRANS (HTRANS), .HWRITE (HWRITE), .HSIZE (HSIZE), .HWDATA (HWDATA),
        .HREADY (HREADY), .HRDATA (HRDATA), .HREADYOUT (HREADYOUT), .HRESP (HRESP),
        .cke (cke), .csN (csN), .rasN (rasN), .casN (casN), .weN (weN),
        .addr (addr), .ba (ba), .dqm (dqm), .dqOut (dqOut), .dqOutEn (dqOutEn),
        .dqIn (dqIn)
    );

    sdramModel #(.initRefreshCount(initRefreshCount)) sdram_i (
        .clk (HCLK), .cke (cke), .csN (csN), .rasN (rasN), .casN (casN), .weN (weN),
        .addr (addr), .ba (ba), .dqm (dqm), .dqOut (dqOut), .dqOutEn (dqOutEn),
        .dqIn (dqIn), .initDone (initDone), .initError (initError),
        .burstError (burstError), .lastWrKey (lastWrKey)
    );

    initial begin
        HCLK = 1'b0;
        forever #(clkPeriod / 2) HCLK = ~HCLK;
    end

    task automatic stopWithFailure();
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic reportFailure(input string what);
        $display("[ERROR] time %0t: %s", $time, what);
        stopWithFailure();
    endtask

    task automatic reportMismatch(input string sig, input logic [31:0] exp,
                                  input logic [31:0] act);
        $display("[ERROR] time %0t: %s expected 0x%08h, got 0x%08h", $time, sig, exp, act);
        stopWithFailure();
    endtask

    // Bus watchdog
    initial begin
        #(timeoutCycles * clkPeriod);
        reportFailure("watchdog timeout, a transfer or init never completed");
    end

    assert property (@(posedge HCLK) HRESP == 1'b0)
        else reportMismatch("HRESP", 32'h0, 32'(HRESP));

    always @(posedge HCLK) begin
        if (HRESETn) begin
            // CKE low time after reset
            if (!cke && !ckeSeenHigh) ckeLowCycles++;
            if (cke && !ckeSeenHigh) begin
                ckeSeenHigh = 1'b1;
                assert (ckeLowCycles == delayNcke + 1)
                    else reportMismatch("ckeLowCycles", delayNcke + 1, ckeLowCycles);
            end
            assert (!(HREADYOUT && !initDone))
                else reportFailure("HREADYOUT high before the mode register load");
            assert (!initError)
                else reportFailure("SDRAM init commands out of order or wrong mode word");
            assert (!burstError)
                else reportFailure("command other than NOP inside an open row or burst");
            if ({cke, csN, rasN, casN, weN} == sdramPkg::cmdAutoRefresh) refGap = 0;
            else refGap++;
            if (idleCheck) begin
                assert (refGap <= refLimit) else reportMismatch("refGap", refLimit, refGap);
            end
        end
    end

    // Byte lanes from HSIZE and the low address bits
    function automatic logic [3:0] laneMask(input logic [31:0] a, input logic [2:0] sz);
        if (sz == ahbPkg::hsizeByte) laneMask = 4'b0001 << a[1:0];
        else if (sz == ahbPkg::hsizeHalf) laneMask = a[1] ? 4'b1100 : 4'b0011;
        else laneMask = 4'b1111;
    endfunction

    function automatic logic [31:0] refWord(input logic [31:0] a);
        refWord = refMem.exists(a[31:2]) ? refMem[a[31:2]] : 32'h0;
    endfunction

    // Bank, row, column word, byte offset from the top down
    function automatic logic [31:0] makeAddress(input logic [1:0] bank, input logic [12:0] row,
                                                input logic [8:0] col, input logic [1:0] off);
        makeAddress = {6'b0, bank, row, col, off};
    endfunction

    // Starts and ends one time unit after a rising edge
    task automatic runTransfer(input logic write, input logic [31:0] a, input logic [2:0] sz,
                               input logic [31:0] data, output logic [31:0] rdata);
        HSEL   = 1'b1;
        HTRANS = htransNonseq;
        HADDR  = a;
        HWRITE = write;
        HSIZE  = sz;
        @(negedge HCLK);
        while (!HREADYOUT) @(negedge HCLK);
        @(posedge HCLK);
        #1;
        // Data phase
        HSEL   = 1'b0;
        HTRANS = ahbPkg::htransIdle;
        HWDATA = data;
        @(negedge HCLK);
        while (!HREADYOUT) @(negedge HCLK);
        rdata = HRDATA;
        @(posedge HCLK);
        #1;
    endtask

    task automatic writeTracked(input logic [31:0] a, input logic [2:0] sz,
                                input logic [31:0] d);
        logic [31:0] ignored;
        logic [31:0] word;
        logic [3:0]  lanes;
        runTransfer(1'b1, a, sz, d, ignored);
        lanes = laneMask(a, sz);
        word  = refWord(a);
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) word[8*b +: 8] = d[8*b +: 8];
        end
        refMem[a[31:2]] = word;
    endtask

    task automatic readChecked(input logic [31:0] a, input logic [2:0] sz);
        logic [31:0] got;
        runTransfer(1'b0, a, sz, 32'h0, got);
        assert (got == refWord(a)) else reportMismatch("HRDATA", refWord(a), got);
    endtask

    initial begin
        logic [31:0] a;
        logic [2:0]  sz;
        int          k;
        HRESETn = 1'b0;
        HSEL    = 1'b0;
        HADDR   = '0;
        HTRANS  = ahbPkg::htransIdle;
        HWRITE  = 1'b0;
        HSIZE   = ahbPkg::hsizeWord;
        HWDATA  = '0;
        repeat (4) @(posedge HCLK);
        #1;
        HRESETn = 1'b1;

        // Init then idle refresh spacing
        @(negedge HCLK);
        while (!HREADYOUT) @(negedge HCLK);
        assert (initDone) else reportFailure("HREADYOUT rose without a mode register load");
        @(posedge HCLK);
        #1;
        idleCheck = 1'b1;
        repeat (idleCycles) @(posedge HCLK);
        #1;
        idleCheck = 1'b0;

        // Word write and read back
        a = makeAddress(2'd2, 13'h0a5c, 9'h13b, 2'd0);
        writeTracked(a, ahbPkg::hsizeWord, 32'hcafe_f00d);
        assert (lastWrKey == {a[25:24], a[23:11], a[10:2], 1'b0})
            else reportMismatch("lastWrKey", 32'({a[25:24], a[23:11], a[10:2], 1'b0}),
                                32'(lastWrKey));
        readChecked(a, ahbPkg::hsizeWord);

        // Bytes and halfwords over a known word
        a = makeAddress(2'd1, 13'h1234, 9'h0f0, 2'd0);
        writeTracked(a, ahbPkg::hsizeWord, 32'h1122_3344);
        for (int off = 0; off < 4; off++) begin
            writeTracked(a + off, ahbPkg::hsizeByte, 32'ha0b0_c0d0 + off);
            readChecked(a + off, ahbPkg::hsizeByte);
        end
        writeTracked(a, ahbPkg::hsizeHalf, 32'h5555_6666);
        readChecked(a, ahbPkg::hsizeHalf);
        writeTracked(a + 2, ahbPkg::hsizeHalf, 32'h7777_8888);
        readChecked(a + 2, ahbPkg::hsizeHalf);

        // Random traffic over distinct banks and rows
        for (int i = 0; i < 8; i++) begin
            pool[i] = makeAddress(2'(i), {3'(i), 10'($random(seed))}, 9'($random(seed)), 2'd0);
        end
        for (int i = 0; i < 40; i++) begin
            k  = $unsigned($random(seed)) % 8;
            sz = 3'($unsigned($random(seed)) % 3);
            a  = pool[k] | ($unsigned($random(seed)) & 32'h3);
            if (sz == ahbPkg::hsizeHalf) a[0] = 1'b0;
            if (sz == ahbPkg::hsizeWord) a[1:0] = 2'b00;
            if ($random(seed) & 1) writeTracked(a, sz, $random(seed));
            else readChecked(a, sz);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- ahbSdram.f
src/ahbPkg.sv
src/sdramPkg.sv
src/ahbCapture.sv
src/sdramSequencer.sv
src/sdramPinDriver.sv
src/ahbSdramTop.sv
verification/sdramModel.sv
verification/ahbSdramTb.sv

//--- run.sh
#!/bin/sh
# Builds the AHB-Lite SDRAM testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ahbSdramTb \
    -f ahbSdram.f -o ahbSdramSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/ahbSdramSim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
